/* coproc_checker.sv */
`timescale 1ns/100ps
// Bound assertions on the output stream and the ALU result timing

`include "coproc_settings.svh"

module coproc_checker (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_tx_val,
  input logic [31:0] i_tx_dat,
  input logic        i_tx_sop,
  input logic        i_tx_eop,
  input logic        i_tx_rdy,
  input logic        i_alu_req_val,
  input logic        i_alu_res_val
);

// Beat held unchanged under back-pressure
a_tx_hold: assert property (@(posedge i_clk) disable iff (i_rst)
  i_tx_val && !i_tx_rdy |=> i_tx_val && $stable(i_tx_dat) && $stable(i_tx_sop)
    && $stable(i_tx_eop))
  else $error("stream beat changed while stalled");

a_tx_reset: assert property (@(posedge i_clk) i_rst |=> !i_tx_val)
  else $error("stream valid high after reset");

a_alu_lat: assert property (@(posedge i_clk) disable iff (i_rst)
  i_alu_req_val |-> ##`COPROC_ALU_LATENCY i_alu_res_val)
  else $error("ALU result missing");

a_alu_src: assert property (@(posedge i_clk) disable iff (i_rst)
  i_alu_res_val |-> $past(i_alu_req_val, `COPROC_ALU_LATENCY))
  else $error("ALU result without request");

endmodule

bind coproc_top coproc_checker u_chk (
  .i_clk         (i_clk),
  .i_rst         (i_rst),
  .i_tx_val      (o_tx_val),
  .i_tx_dat      (o_tx_dat),
  .i_tx_sop      (o_tx_sop),
  .i_tx_eop      (o_tx_eop),
  .i_tx_rdy      (i_tx_rdy),
  .i_alu_req_val (alu_req_val),
  .i_alu_res_val (alu_res_val)
);

/* coproc_irq_tx.sv */
`timescale 1ns/100ps
// Interrupt transmitter: header beat, then up to two buffered slot words
// out on a ready-based stream

module coproc_irq_tx
  import coproc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_hdr_val,
  input  irq_hdr_t i_hdr,
  input  logic     i_word_val,
  input  fe_t      i_word,
  output logic     o_idle,
  output fe_t      o_tx_dat,
  output logic     o_tx_val,
  output logic     o_tx_sop,
  output logic     o_tx_eop,
  input  logic     i_tx_rdy
);

typedef enum logic [1:0] {
  WAIT_HDR,
  SEND_HDR,
  SEND_DATA
} tx_state_t;

tx_state_t  state;
irq_hdr_t   hdr_l;
fe_t        word_buf [2];
logic [1:0] wr_cnt;
logic [1:0] rem;
logic [1:0] rd_idx;
logic       adv;

assign o_idle = (state == WAIT_HDR);
// Output beat may be replaced once taken or empty
assign adv    = !o_tx_val || i_tx_rdy;
assign rd_idx = hdr_l.count - rem;

always_ff @(posedge i_clk) begin
  if (i_word_val) word_buf[wr_cnt[0]] <= i_word;
  if (i_hdr_val && state == WAIT_HDR) hdr_l <= i_hdr;
  if (adv) begin
    if (state == SEND_HDR) begin
      o_tx_dat <= fe_t'(hdr_l);
    end else if (state == SEND_DATA) begin
      o_tx_dat <= word_buf[rd_idx[0]];
    end
  end
end

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    state    <= WAIT_HDR;
    wr_cnt   <= '0;
    rem      <= '0;
    o_tx_val <= 1'b0;
    o_tx_sop <= 1'b0;
    o_tx_eop <= 1'b0;
  end else begin
    if (i_word_val) wr_cnt <= wr_cnt + 1'b1;
    case (state)
      WAIT_HDR: begin
        if (i_hdr_val) begin
          rem    <= i_hdr.count;
          wr_cnt <= '0;
          state  <= SEND_HDR;
        end
      end
      SEND_HDR: begin
        if (adv) begin
          o_tx_val <= 1'b1;
          o_tx_sop <= 1'b1;
          o_tx_eop <= 1'b0;
          state    <= SEND_DATA;
        end
      end
      SEND_DATA: begin
        if (adv) begin
          o_tx_sop <= 1'b0;
          if (rem == 0) begin
            // Last word taken
            o_tx_val <= 1'b0;
            o_tx_eop <= 1'b0;
            state    <= WAIT_HDR;
          end else if (wr_cnt > rd_idx) begin
            o_tx_val <= 1'b1;
            o_tx_eop <= (rem == 2'd1);
            rem      <= rem - 1'b1;
          end else begin
            o_tx_val <= 1'b0;
          end
        end
      end
      default: state <= WAIT_HDR;
    endcase
  end
end

endmodule

/* coproc_mod_alu.sv */
`timescale 1ns/100ps
// Two-stage modular adder and subtractor on reduced field elements

`include "coproc_settings.svh"

module coproc_mod_alu
  import coproc_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_req_val,
  input  alu_req_t i_req,
  output logic     o_res_val,
  output fe_t      o_res
);

localparam logic [`COPROC_FE_W:0] MOD = {1'b0, `COPROC_MODULUS};

// Top bit holds the carry of a sum or the borrow of a difference
logic [`COPROC_FE_W:0] raw_s1;
alu_op_t               op_s1;
logic                  val_s1;

always_ff @(posedge i_clk) begin
  if (i_req.op == ALU_ADD) begin
    raw_s1 <= {1'b0, i_req.x} + {1'b0, i_req.y};
  end else begin
    raw_s1 <= {1'b0, i_req.x} - {1'b0, i_req.y};
  end
  op_s1 <= i_req.op;

  // Correction stage
  if (op_s1 == ALU_ADD) begin
    o_res <= (raw_s1 >= MOD) ? fe_t'(raw_s1 - MOD) : fe_t'(raw_s1);
  end else begin
    // Borrow set when x < y so the modulus goes back in
    o_res <= raw_s1[`COPROC_FE_W] ? fe_t'(raw_s1 + MOD) : fe_t'(raw_s1);
  end
end

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    val_s1    <= 1'b0;
    o_res_val <= 1'b0;
  end else begin
    val_s1    <= i_req_val;
    o_res_val <= val_s1;
  end
end

endmodule

/* coproc_pkg.sv */
// Shared types: field elements, RAM addresses, slot and instruction words,
// ALU requests and the interrupt header

`include "coproc_settings.svh"

package coproc_pkg;

typedef logic [`COPROC_FE_W-1:0]    fe_t;
typedef logic [`COPROC_INST_AW-1:0] inst_addr_t;
typedef logic [`COPROC_DATA_AW-1:0] data_addr_t;

// FE2 marks the first of two adjacent slots
typedef enum logic [1:0] {
  ELEM_FE  = 2'd0,
  ELEM_FE2 = 2'd1
} elem_type_t;

typedef struct packed {
  elem_type_t etype;
  fe_t        val;
} data_word_t;

typedef enum logic [3:0] {
  NOOP             = 4'd0,
  JUMP             = 4'd1,
  JUMP_IF_EQ       = 4'd2,
  JUMP_NONZERO_SUB = 4'd3,
  COPY_REG         = 4'd4,
  ADD_ELEMENT      = 4'd5,
  SUB_ELEMENT      = 4'd6,
  SEND_INTERRUPT   = 4'd7
} inst_code_t;

typedef struct packed {
  inst_code_t code;
  data_addr_t a;
  data_addr_t b;
  data_addr_t c;
} inst_t;

typedef enum logic {
  ALU_ADD = 1'b0,
  ALU_SUB = 1'b1
} alu_op_t;

typedef struct packed {
  alu_op_t op;
  fe_t     x;
  fe_t     y;
} alu_req_t;

// Sits in the low bits of the header beat
typedef struct packed {
  logic [`COPROC_TAG_W-1:0] tag;
  elem_type_t               etype;
  logic [1:0]               count;
} irq_hdr_t;

endpackage

/* coproc_ram.sv */
`timescale 1ns/100ps
// True dual-port RAM with a pipelined read and a read valid per port

`include "coproc_settings.svh"

module coproc_ram #(
  parameter int RAM_WIDTH = 32,
  parameter int RAM_DEPTH = 256
) (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_a_we,
  input  logic [$clog2(RAM_DEPTH)-1:0] i_a_addr,
  input  logic [RAM_WIDTH-1:0]         i_a_wdat,
  input  logic                         i_a_re,
  output logic [RAM_WIDTH-1:0]         o_a_rdat,
  output logic                         o_a_rval,
  input  logic                         i_b_we,
  input  logic [$clog2(RAM_DEPTH)-1:0] i_b_addr,
  input  logic [RAM_WIDTH-1:0]         i_b_wdat,
  input  logic                         i_b_re,
  output logic [RAM_WIDTH-1:0]         o_b_rdat,
  output logic                         o_b_rval
);

localparam int LAT = `COPROC_RAM_LATENCY;

logic [RAM_WIDTH-1:0] mem    [RAM_DEPTH];
logic [RAM_WIDTH-1:0] a_pipe [LAT];
logic [RAM_WIDTH-1:0] b_pipe [LAT];
logic [LAT-1:0]       a_vld;
logic [LAT-1:0]       b_vld;

always_ff @(posedge i_clk) begin
  if (i_a_we) mem[i_a_addr] <= i_a_wdat;
  if (i_b_we) mem[i_b_addr] <= i_b_wdat;
  a_pipe[0] <= mem[i_a_addr];
  b_pipe[0] <= mem[i_b_addr];
  for (int i = 1; i < LAT; i++) begin
    a_pipe[i] <= a_pipe[i-1];
    b_pipe[i] <= b_pipe[i-1];
  end
end

// Valid bits travel alongside the read data
always_ff @(posedge i_clk) begin
  if (i_rst) begin
    a_vld <= '0;
    b_vld <= '0;
  end else begin
    a_vld <= (a_vld << 1) | LAT'(i_a_re);
    b_vld <= (b_vld << 1) | LAT'(i_b_re);
  end
end

assign o_a_rdat = a_pipe[LAT-1];
assign o_a_rval = a_vld[LAT-1];
assign o_b_rdat = b_pipe[LAT-1];
assign o_b_rval = b_vld[LAT-1];

endmodule

/* coproc_sequencer.sv */
`timescale 1ns/100ps
// Instruction fetch and execute FSM driving port B of both RAMs,
// the modular ALU and the interrupt transmitter

module coproc_sequencer
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_start,
  input  inst_addr_t i_start_pt,
  output logic       o_busy,
  // Instruction RAM port B
  output inst_addr_t o_inst_addr,
  output logic       o_inst_re,
  input  inst_t      i_inst_rdat,
  input  logic       i_inst_rval,
  // Data RAM port B
  output data_addr_t o_data_addr,
  output logic       o_data_re,
  output logic       o_data_we,
  output data_word_t o_data_wdat,
  input  data_word_t i_data_rdat,
  input  logic       i_data_rval,
  // ALU
  output logic       o_alu_val,
  output alu_req_t   o_alu_req,
  input  logic       i_alu_val,
  input  fe_t        i_alu_res,
  // Interrupt transmitter
  input  logic       i_irq_idle,
  output logic       o_irq_hdr_val,
  output irq_hdr_t   o_irq_hdr,
  output logic       o_irq_word_val,
  output fe_t        o_irq_word
);

typedef enum logic [3:0] {
  ST_FETCH, ST_NOOP, ST_JUMP, ST_JUMP_IF_EQ, ST_JUMP_NZ_SUB,
  ST_COPY_REG, ST_ADD, ST_SUB, ST_SEND_IRQ
} seq_state_t;

seq_state_t state;
logic [1:0] step;
inst_addr_t pc;
inst_t      inst_l;
logic       start_pend;
inst_addr_t start_pt_l;
fe_t        x_l;
elem_type_t etype_l;
logic       hi;

assign o_inst_addr = pc;

function automatic seq_state_t decode(input inst_code_t code);
  case (code)
    JUMP:             return ST_JUMP;
    JUMP_IF_EQ:       return ST_JUMP_IF_EQ;
    JUMP_NONZERO_SUB: return ST_JUMP_NZ_SUB;
    COPY_REG:         return ST_COPY_REG;
    ADD_ELEMENT:      return ST_ADD;
    SUB_ELEMENT:      return ST_SUB;
    SEND_INTERRUPT:   return ST_SEND_IRQ;
    default:          return ST_NOOP;
  endcase
endfunction

task next_inst(input inst_addr_t addr);
  pc        <= addr;
  o_inst_re <= 1'b1;
  state     <= ST_FETCH;
endtask

task read_slot(input data_addr_t addr);
  o_data_addr <= addr;
  o_data_re   <= 1'b1;
endtask

task write_slot(input data_addr_t addr, input data_word_t word);
  o_data_addr <= addr;
  o_data_wdat <= word;
  o_data_we   <= 1'b1;
endtask

always_ff @(posedge i_clk) begin
  if (i_rst) begin
    state          <= ST_NOOP;
    step           <= '0;
    pc             <= '0;
    hi             <= 1'b0;
    start_pend     <= 1'b0;
    o_busy         <= 1'b0;
    o_inst_re      <= 1'b0;
    o_data_re      <= 1'b0;
    o_data_we      <= 1'b0;
    o_alu_val      <= 1'b0;
    o_irq_hdr_val  <= 1'b0;
    o_irq_word_val <= 1'b0;
  end else begin
    o_inst_re      <= 1'b0;
    o_data_re      <= 1'b0;
    o_data_we      <= 1'b0;
    o_alu_val      <= 1'b0;
    o_irq_hdr_val  <= 1'b0;
    o_irq_word_val <= 1'b0;

    case (state)
      ST_NOOP: begin
        // Halted on the NOOP address until a new start
        if (start_pend) begin
          start_pend <= 1'b0;
          next_inst(start_pt_l);
        end
      end
      ST_FETCH: begin
        if (i_inst_rval) begin
          inst_l <= i_inst_rdat;
          state  <= decode(i_inst_rdat.code);
          step   <= '0;
          hi     <= 1'b0;
          if (decode(i_inst_rdat.code) == ST_NOOP) o_busy <= start_pend;
        end
      end
      ST_JUMP: next_inst(inst_addr_t'(inst_l.a));
      ST_JUMP_IF_EQ: begin
        case (step)
          2'd0: begin
            read_slot(inst_l.b);
            step <= 2'd1;
          end
          2'd1: begin
            if (i_data_rval) begin
              x_l  <= i_data_rdat.val;
              read_slot(inst_l.c);
              step <= 2'd2;
            end
          end
          default: begin
            if (i_data_rval) begin
              next_inst(i_data_rdat.val == x_l ? inst_addr_t'(inst_l.a) : pc + 1'b1);
            end
          end
        endcase
      end
      ST_JUMP_NZ_SUB: begin
        if (step == 2'd0) begin
          read_slot(inst_l.b);
          step <= 2'd1;
        end else if (i_data_rval) begin
          if (i_data_rdat.val != '0) begin
            write_slot(inst_l.b, '{etype: i_data_rdat.etype, val: i_data_rdat.val - 1'b1});
            next_inst(inst_addr_t'(inst_l.a));
          end else begin
            next_inst(pc + 1'b1);
          end
        end
      end
      ST_COPY_REG: begin
        if (step == 2'd0) begin
          read_slot(inst_l.a);
          step <= 2'd1;
        end else if (i_data_rval) begin
          write_slot(inst_l.b, i_data_rdat);
          next_inst(pc + 1'b1);
        end
      end
      ST_ADD, ST_SUB: begin
        // hi selects the second slot of an FE2 pair
        case (step)
          2'd0: begin
            read_slot(inst_l.a + hi);
            step <= 2'd1;
          end
          2'd1: begin
            if (i_data_rval) begin
              x_l <= i_data_rdat.val;
              if (!hi) etype_l <= i_data_rdat.etype;
              read_slot(inst_l.b + hi);
              step <= 2'd2;
            end
          end
          2'd2: begin
            if (i_data_rval) begin
              o_alu_val    <= 1'b1;
              o_alu_req.op <= (state == ST_SUB) ? ALU_SUB : ALU_ADD;
              o_alu_req.x  <= x_l;
              o_alu_req.y  <= i_data_rdat.val;
              step         <= 2'd3;
            end
          end
          default: begin
            if (i_alu_val) begin
              write_slot(inst_l.c + hi, '{etype: etype_l, val: i_alu_res});
              if (etype_l == ELEM_FE2 && !hi) begin
                hi   <= 1'b1;
                step <= 2'd0;
              end else begin
                next_inst(pc + 1'b1);
              end
            end
          end
        endcase
      end
      ST_SEND_IRQ: begin
        case (step)
          2'd0: begin
            if (i_irq_idle) begin
              read_slot(inst_l.a);
              step <= 2'd1;
            end
          end
          2'd1: begin
            if (i_data_rval) begin
              o_irq_hdr_val   <= 1'b1;
              o_irq_hdr.tag   <= inst_l.b;
              o_irq_hdr.etype <= i_data_rdat.etype;
              o_irq_hdr.count <= (i_data_rdat.etype == ELEM_FE2) ? 2'd2 : 2'd1;
              x_l     <= i_data_rdat.val;
              etype_l <= i_data_rdat.etype;
              step    <= 2'd2;
            end
          end
          2'd2: begin
            o_irq_word_val <= 1'b1;
            o_irq_word     <= x_l;
            if (etype_l == ELEM_FE2) begin
              read_slot(inst_l.a + 1'b1);
              step <= 2'd3;
            end else begin
              next_inst(pc + 1'b1);
            end
          end
          default: begin
            if (i_data_rval) begin
              o_irq_word_val <= 1'b1;
              o_irq_word     <= i_data_rdat.val;
              next_inst(pc + 1'b1);
            end
          end
        endcase
      end
      default: state <= ST_NOOP;
    endcase

    // A new start pointer is held until the sequencer is idle
    if (i_start) begin
      start_pend <= 1'b1;
      start_pt_l <= i_start_pt;
      o_busy     <= 1'b1;
    end
  end
end

endmodule

/* coproc_settings.svh */
// Widths, depths, modulus and pipeline latencies of the coprocessor
`ifndef COPROC_SETTINGS_SVH
`define COPROC_SETTINGS_SVH

// Field element width and prime
`define COPROC_FE_W 32
`define COPROC_MODULUS 32'hFFFFFFFB

// RAM address widths, 256 entries each
`define COPROC_INST_AW 8
`define COPROC_DATA_AW 8

// Read latency of both RAMs in cycles
`define COPROC_RAM_LATENCY 2

// Modular ALU latency in cycles
`define COPROC_ALU_LATENCY 2

// Interrupt tag width
`define COPROC_TAG_W 8

`endif

/* coproc_tb.sv */
`timescale 1ns/100ps
// Testbench for coproc_top with program loading, reference model, LFSR stimulus,
// slot readback and stream beat checking

`include "coproc_settings.svh"

module coproc_tb
  import coproc_pkg::*;
;

localparam fe_t MOD = `COPROC_MODULUS;

logic i_clk = 1'b0;
logic i_rst;
logic i_inst_we;
inst_addr_t i_inst_addr;
inst_t i_inst_wdat;
logic i_data_we;
logic i_data_re;
data_addr_t i_data_addr;
data_word_t i_data_wdat;
data_word_t o_data_rdat;
logic o_data_rval;
logic i_start;
inst_addr_t i_start_pt;
logic o_busy;
fe_t o_tx_dat;
logic o_tx_val;
logic o_tx_sop;
logic o_tx_eop;
logic i_tx_rdy;

inst_t ref_prog [256];
data_word_t ref_mem [256];
logic [33:0] exp_q [$];
logic [31:0] lfsr_state = 32'hcfa9f9d0;
int err_cnt = 0;
int other_err = 0;
int inst_count = 0;
logic load_done = 1'b0;
logic rdy_rand = 1'b0;

always #5 i_clk = ~i_clk;

coproc_top DUT (.*);

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    r = {r[30:0], lfsr_state[0]};
  end
  return r;
endfunction

function automatic fe_t rand_fe();
  fe_t v;
  v = take_bits(32);
  return (v >= MOD) ? v - MOD : v;
endfunction

function automatic fe_t ref_alu(input alu_op_t op, input fe_t x, input fe_t y);
  logic [32:0] s;
  if (op == ALU_ADD) s = {1'b0, x} + {1'b0, y};
  else s = {1'b0, x} + {1'b0, MOD} - {1'b0, y};
  if (s >= {1'b0, MOD}) s = s - {1'b0, MOD};
  return s[31:0];
endfunction

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
  if (exp !== got) begin
    err_cnt++;
    $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
  end
endtask

// Runs a program on the model memory and queues the expected beats
task automatic ref_run(input inst_addr_t pt);
  inst_addr_t pc;
  inst_t ins;
  elem_type_t t;
  logic [1:0] cnt;
  bit halted;
  pc = pt;
  halted = 0;
  for (int n = 0; n < 1000 && !halted; n++) begin
    ins = ref_prog[pc];
    pc = pc + 8'd1;
    case (ins.code)
      JUMP: pc = ins.a;
      JUMP_IF_EQ: if (ref_mem[ins.b].val == ref_mem[ins.c].val) pc = ins.a;
      JUMP_NONZERO_SUB: begin
        if (ref_mem[ins.b].val != 0) begin
          ref_mem[ins.b].val = ref_mem[ins.b].val - 32'd1;
          pc = ins.a;
        end
      end
      COPY_REG: ref_mem[ins.b] = ref_mem[ins.a];
      ADD_ELEMENT, SUB_ELEMENT: begin
        t = ref_mem[ins.a].etype;
        for (int k = 0; k < ((t == ELEM_FE2) ? 2 : 1); k++) begin
          ref_mem[ins.c + k].val = ref_alu((ins.code == SUB_ELEMENT) ? ALU_SUB : ALU_ADD,
                                           ref_mem[ins.a + k].val, ref_mem[ins.b + k].val);
          ref_mem[ins.c + k].etype = t;
        end
      end
      SEND_INTERRUPT: begin
        t = ref_mem[ins.a].etype;
        cnt = (t == ELEM_FE2) ? 2'd2 : 2'd1;
        exp_q.push_back({2'b10, 20'd0, ins.b, t, cnt});
        exp_q.push_back({1'b0, cnt == 2'd1, ref_mem[ins.a].val});
        if (t == ELEM_FE2) exp_q.push_back({2'b01, ref_mem[ins.a + 8'd1].val});
      end
      default: halted = 1;
    endcase
  end
endtask

task automatic load_inst(input inst_addr_t addr, input inst_code_t code,
                         input data_addr_t a, input data_addr_t b, input data_addr_t c);
  @(posedge i_clk) #1;
  i_inst_we = 1'b1;
  i_inst_addr = addr;
  i_inst_wdat = '{code: code, a: a, b: b, c: c};
  ref_prog[addr] = i_inst_wdat;
  inst_count++;
  @(posedge i_clk) #1;
  i_inst_we = 1'b0;
endtask

task automatic load_slot(input data_addr_t addr, input elem_type_t t, input fe_t v);
  @(posedge i_clk) #1;
  i_data_we = 1'b1;
  i_data_addr = addr;
  i_data_wdat = '{etype: t, val: v};
  ref_mem[addr] = i_data_wdat;
  @(posedge i_clk) #1;
  i_data_we = 1'b0;
endtask

// Read data and valid arrive a fixed RAM latency after the request
task automatic host_read(input data_addr_t addr, output data_word_t w);
  @(posedge i_clk) #1;
  i_data_re = 1'b1;
  i_data_addr = addr;
  for (int k = 1; k < `COPROC_RAM_LATENCY; k++) begin
    @(posedge i_clk) #1;
    i_data_re = 1'b0;
    check("o_data_rval", 64'd0, {63'd0, o_data_rval});
  end
  @(posedge i_clk) #1;
  i_data_re = 1'b0;
  check("o_data_rval", 64'd1, {63'd0, o_data_rval});
  w = o_data_rdat;
  @(posedge i_clk) #1;
  check("o_data_rval", 64'd0, {63'd0, o_data_rval});
endtask

task automatic verify_slots();
  data_word_t w;
  for (int i = 0; i < 64; i++) begin
    host_read(data_addr_t'(i), w);
    check($sformatf("slot %0d", i), {30'd0, ref_mem[i]}, {30'd0, w});
  end
endtask

task automatic run_program(input inst_addr_t pt);
  ref_run(pt);
  @(posedge i_clk) #1;
  i_start = 1'b1;
  i_start_pt = pt;
  @(posedge i_clk) #1;
  i_start = 1'b0;
  check("o_busy", 64'd1, {63'd0, o_busy});
  while (o_busy) @(posedge i_clk);
  verify_slots();
endtask

// Stream monitor
always @(posedge i_clk) begin
  if (!i_rst && o_tx_val && i_tx_rdy) begin
    if (exp_q.size() == 0) begin
      other_err++;
      $display("Unexpected stream beat %h at %0t", o_tx_dat, $time);
    end else begin
      check("o_tx beat {sop,eop,dat}", {30'd0, exp_q.pop_front()},
            {30'd0, o_tx_sop, o_tx_eop, o_tx_dat});
    end
  end
end

always @(posedge i_clk) begin
  #1;
  if (rdy_rand) i_tx_rdy = (take_bits(1) != 0);
end

// Watchdog
initial begin
  wait (load_done);
  #(inst_count * 200 * 10);
  $display("Timeout: the run did not finish in time");
  $display("SIMULATION FAILED");
  $finish;
end

initial begin
  fe_t v;
  int n;
  i_rst = 1'b1;
  i_inst_we = 1'b0;
  i_inst_addr = '0;
  i_inst_wdat = '0;
  i_data_we = 1'b0;
  i_data_re = 1'b0;
  i_data_addr = '0;
  i_data_wdat = '0;
  i_start = 1'b0;
  i_start_pt = '0;
  i_tx_rdy = 1'b1;
  repeat (10) @(posedge i_clk);
  #1 i_rst = 1'b0;
  check("o_busy", 64'd0, {63'd0, o_busy});
  check("o_tx_val", 64'd0, {63'd0, o_tx_val});

  for (int i = 0; i < 64; i++) begin
    load_slot(data_addr_t'(i), ELEM_FE, {i[7:0], i[7:0] ^ 8'hA5, ~i[7:0], i[7:0] + 8'h3C});
  end
  load_slot(0, ELEM_FE, rand_fe());
  load_slot(1, ELEM_FE, rand_fe());
  load_slot(2, ELEM_FE, MOD - 32'd1);
  load_slot(3, ELEM_FE, MOD - 32'd2);
  load_slot(4, ELEM_FE, take_bits(8));
  load_slot(5, ELEM_FE, (take_bits(32) | 32'h8000_0000) & 32'hFFFF_0000);
  load_slot(10, ELEM_FE2, rand_fe());
  load_slot(11, ELEM_FE, rand_fe());
  load_slot(12, ELEM_FE2, rand_fe());
  load_slot(13, ELEM_FE, rand_fe());
  load_slot(40, ELEM_FE, 32'd5);
  load_slot(41, ELEM_FE, rand_fe());
  load_slot(42, ELEM_FE, rand_fe());
  v = rand_fe();
  load_slot(43, ELEM_FE, v);
  load_slot(44, ELEM_FE, v);
  load_slot(45, ELEM_FE, v ^ 32'd1);

  // Arithmetic, FE2 and copy
  load_inst(0, ADD_ELEMENT, 0, 1, 20);
  load_inst(1, SUB_ELEMENT, 0, 1, 21);
  load_inst(2, ADD_ELEMENT, 2, 3, 22);
  load_inst(3, SUB_ELEMENT, 4, 5, 23);
  load_inst(4, ADD_ELEMENT, 10, 12, 24);
  load_inst(5, SUB_ELEMENT, 10, 12, 26);
  load_inst(6, COPY_REG, 10, 30, 0);
  load_inst(7, NOOP, 0, 0, 0);
  // Counted loop, then conditional skips
  load_inst(16, JUMP_NONZERO_SUB, 18, 40, 0);
  load_inst(17, JUMP, 20, 0, 0);
  load_inst(18, ADD_ELEMENT, 41, 42, 41);
  load_inst(19, JUMP, 16, 0, 0);
  load_inst(20, JUMP_IF_EQ, 22, 43, 44);
  load_inst(21, ADD_ELEMENT, 41, 42, 41);
  load_inst(22, JUMP_IF_EQ, 24, 43, 45);
  load_inst(23, ADD_ELEMENT, 42, 42, 46);
  load_inst(24, NOOP, 0, 0, 0);
  // Interrupts
  load_inst(32, SEND_INTERRUPT, 0, 8'h5A, 0);
  load_inst(33, SEND_INTERRUPT, 10, 8'hA5, 0);
  load_inst(34, NOOP, 0, 0, 0);
  load_done = 1'b1;
  rdy_rand = 1'b1;

  run_program(0);
  run_program(16);
  run_program(32);
  n = 0;
  while (exp_q.size() != 0 && n < 200) begin
    @(posedge i_clk);
    n++;
  end
  if (exp_q.size() != 0) begin
    other_err++;
    $display("Stream ended with %0d expected beats missing", exp_q.size());
  end

  $display("Checks done: %0d value errors, %0d other errors", err_cnt, other_err);
  if (err_cnt == 0 && other_err == 0) begin
    $display("SIMULATION PASSED");
  end else begin
    $display("SIMULATION FAILED");
  end
  $finish;
end

endmodule

/* coproc_top.f */
+incdir+.
coproc_pkg.sv
coproc_ram.sv
coproc_mod_alu.sv
coproc_irq_tx.sv
coproc_sequencer.sv
coproc_top.sv
coproc_checker.sv
coproc_tb.sv

/* coproc_top.sv */
`timescale 1ns/100ps
// Coprocessor top: sequencer, instruction and data RAMs, modular ALU
// and interrupt transmitter

`include "coproc_settings.svh"

module coproc_top
  import coproc_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  // Host access
  input  logic       i_inst_we,
  input  inst_addr_t i_inst_addr,
  input  inst_t      i_inst_wdat,
  input  logic       i_data_we,
  input  logic       i_data_re,
  input  data_addr_t i_data_addr,
  input  data_word_t i_data_wdat,
  output data_word_t o_data_rdat,
  output logic       o_data_rval,
  input  logic       i_start,
  input  inst_addr_t i_start_pt,
  output logic       o_busy,
  // Interrupt stream
  output fe_t        o_tx_dat,
  output logic       o_tx_val,
  output logic       o_tx_sop,
  output logic       o_tx_eop,
  input  logic       i_tx_rdy
);

inst_addr_t inst_addr;
logic       inst_re;
inst_t      inst_rdat;
logic       inst_rval;
data_addr_t data_addr;
logic       data_re;
logic       data_we;
data_word_t data_wdat;
data_word_t data_rdat;
logic       data_rval;
logic       alu_req_val;
alu_req_t   alu_req;
logic       alu_res_val;
fe_t        alu_res;
logic       irq_idle;
logic       irq_hdr_val;
irq_hdr_t   irq_hdr;
logic       irq_word_val;
fe_t        irq_word;

coproc_sequencer u_seq (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_start        (i_start),
  .i_start_pt     (i_start_pt),
  .o_busy         (o_busy),
  .o_inst_addr    (inst_addr),
  .o_inst_re      (inst_re),
  .i_inst_rdat    (inst_rdat),
  .i_inst_rval    (inst_rval),
  .o_data_addr    (data_addr),
  .o_data_re      (data_re),
  .o_data_we      (data_we),
  .o_data_wdat    (data_wdat),
  .i_data_rdat    (data_rdat),
  .i_data_rval    (data_rval),
  .o_alu_val      (alu_req_val),
  .o_alu_req      (alu_req),
  .i_alu_val      (alu_res_val),
  .i_alu_res      (alu_res),
  .i_irq_idle     (irq_idle),
  .o_irq_hdr_val  (irq_hdr_val),
  .o_irq_hdr      (irq_hdr),
  .o_irq_word_val (irq_word_val),
  .o_irq_word     (irq_word)
);

// Host port A is write-only here
coproc_ram #(
  .RAM_WIDTH ($bits(inst_t)),
  .RAM_DEPTH (1 << `COPROC_INST_AW)
) inst_ram (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_a_we   (i_inst_we),
  .i_a_addr (i_inst_addr),
  .i_a_wdat (i_inst_wdat),
  .i_a_re   (1'b0),
  .o_a_rdat (),
  .o_a_rval (),
  .i_b_we   (1'b0),
  .i_b_addr (inst_addr),
  .i_b_wdat ('0),
  .i_b_re   (inst_re),
  .o_b_rdat (inst_rdat),
  .o_b_rval (inst_rval)
);

coproc_ram #(
  .RAM_WIDTH ($bits(data_word_t)),
  .RAM_DEPTH (1 << `COPROC_DATA_AW)
) data_ram (
  .i_clk    (i_clk),
  .i_rst    (i_rst),
  .i_a_we   (i_data_we),
  .i_a_addr (i_data_addr),
  .i_a_wdat (i_data_wdat),
  .i_a_re   (i_data_re),
  .o_a_rdat (o_data_rdat),
  .o_a_rval (o_data_rval),
  .i_b_we   (data_we),
  .i_b_addr (data_addr),
  .i_b_wdat (data_wdat),
  .i_b_re   (data_re),
  .o_b_rdat (data_rdat),
  .o_b_rval (data_rval)
);

coproc_mod_alu u_alu (
  .i_clk     (i_clk),
  .i_rst     (i_rst),
  .i_req_val (alu_req_val),
  .i_req     (alu_req),
  .o_res_val (alu_res_val),
  .o_res     (alu_res)
);

coproc_irq_tx u_irq_tx (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_hdr_val  (irq_hdr_val),
  .i_hdr      (irq_hdr),
  .i_word_val (irq_word_val),
  .i_word     (irq_word),
  .o_idle     (irq_idle),
  .o_tx_dat   (o_tx_dat),
  .o_tx_val   (o_tx_val),
  .o_tx_sop   (o_tx_sop),
  .o_tx_eop   (o_tx_eop),
  .i_tx_rdy   (i_tx_rdy)
);

endmodule

/* run_sim.sh */
#!/bin/bash
# Build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f coproc_top.f \
       --top-module coproc_tb -o coproc_sim \
  && ./obj_dir/coproc_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "run_sim: pass" \
  || { echo "run_sim: fail"; exit 1; }
